// ==== logic/relay_defs.svh ====
// relay computer defines: bus widths, sequencer step counts and instruction lengths
`ifndef RELAY_DEFS_SVH
`define RELAY_DEFS_SVH

`define RELAY_DATA_W 8        // data bus and register width
`define RELAY_ADDR_W 16       // address bus, PC, M, XY, J

// sequencer
`define RELAY_NUM_STEPS 24    // longest instruction (GOTO)
`define RELAY_FETCH_STEPS 4   // steps 1..4 are fetch/increment

// instruction lengths in steps
`define RELAY_LEN_SHORT 8     // MOV8, SETAB, ALU
`define RELAY_LEN_MEM 12      // LOAD, STORE
`define RELAY_LEN_INC 14      // INC16, HALT
`define RELAY_LEN_GOTO 24

`endif

// ==== logic/relay_isa_pkg.sv ====
// relay isa types: instruction classes, register selects, alu functions, condition codes
package relay_isa_pkg;

  typedef enum logic [3:0] {
    IC_MOV8,     // 00dddsss
    IC_SETAB,    // 01rvvvvv
    IC_ALU,      // 1000rfff
    IC_LOAD,     // 100100rr
    IC_STORE,    // 100110rr
    IC_INC16,    // 10110000
    IC_GOTO,     // 11scznxl
    IC_HALT,     // 10101110
    IC_ILLEGAL
  } inst_class_e;

  // same order as the 3-bit register fields in MOV8
  typedef enum logic [2:0] {
    R_A, R_B, R_C, R_D, R_M1, R_M2, R_X, R_Y
  } reg8_e;

  typedef enum logic [2:0] {
    FN_ADD, FN_INC, FN_AND, FN_OR, FN_XOR, FN_NOT, FN_SHL, FN_CLR
  } alu_fn_e;

  typedef struct packed {
    logic sign;
    logic carry;
    logic zero;
  } ccr_t;

endpackage

// ==== logic/relay_ctrl_pkg.sv ====
// relay control types: decoder control bus and memory port bundle
`include "relay_defs.svh"

package relay_ctrl_pkg;

  typedef struct packed {
    // register load enables
    logic ld_a, ld_b, ld_c, ld_d;
    logic ld_m1, ld_m2, ld_x, ld_y;
    logic ld_j1, ld_j2;
    logic ld_xy;                      // 16-bit load from address bus
    logic ld_pc, ld_inc, ld_inst;
    logic ld_ccr;
    // data bus sources
    relay_isa_pkg::reg8_e sel_src;
    logic sel_src_en;
    logic sel_imm;                    // SETAB immediate
    logic sel_alu;
    relay_isa_pkg::alu_fn_e alu_fn;
    logic alu_to_d;                   // alu result goes to D, else A
    // address bus sources, at most one
    logic sel_pc, sel_m, sel_xy, sel_j, sel_inc;
  } ctrl_bus_t;

  typedef struct packed {
    logic mem_read;
    logic mem_write;
    logic [`RELAY_ADDR_W-1:0] addr;
    logic [`RELAY_DATA_W-1:0] wdata;
  } mem_bus_t;

endpackage

// ==== logic/pulse_sequencer.sv ====
// pulse sequencer: one-hot step ring with lengthened pulses, restart and halt
`include "relay_defs.svh"

module pulse_sequencer (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        run,
  input  logic                        inst_done,
  input  logic                        halt_req,
  output logic [`RELAY_NUM_STEPS-1:0] step,
  output logic [`RELAY_NUM_STEPS-1:0] step_prime,
  output logic                        halted
);

  localparam int N = `RELAY_NUM_STEPS;

  logic [N-1:0] step_q;     // ring state, bit 0 is step 1
  logic [N-1:0] step_prev;  // step seen last clock

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_q    <= N'(1);
      step_prev <= '0;
      halted    <= 1'b0;
    end else begin
      step_prev <= step;
      if (run && !halted) begin
        if (halt_req) begin
          step_q <= '0;     // ring stops, no more pulses
          halted <= 1'b1;
        end else if (inst_done) begin
          step_q <= N'(1);  // next instruction
        end else begin
          step_q <= {step_q[N-2:0], step_q[N-1]};
        end
      end
    end
  end

  // pulses only while running
  assign step = run ? step_q : '0;

  // pulse stretched into the following step
  assign step_prime = step | step_prev;

  a_step_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    run && !halted |-> $onehot(step));

  // shortest instruction ends at step 8
  a_done_not_early: assert property (@(posedge clk) disable iff (!rst_n)
    inst_done |-> ~|step[`RELAY_LEN_SHORT-2:0]);

endmodule

// ==== logic/instruction_decoder.sv ====
// instruction decoder: instruction byte and step pulses to control bus and memory strobes
`include "relay_defs.svh"

module instruction_decoder (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`RELAY_DATA_W-1:0]    inst,
  input  logic [`RELAY_NUM_STEPS-1:0] step,
  input  logic [`RELAY_NUM_STEPS-1:0] step_prime,
  input  relay_isa_pkg::ccr_t         ccr,
  output relay_ctrl_pkg::ctrl_bus_t   ctrl,
  output logic                        mem_read,
  output logic                        mem_write,
  output logic                        inst_done,
  output logic                        halt_req
);

  logic [`RELAY_NUM_STEPS:1] s;     // s[n] is step n
  logic [`RELAY_NUM_STEPS:1] sp;    // lengthened pulses
  relay_isa_pkg::inst_class_e cls;
  logic [7:0] r8_ld;                // per-register load, indexed by reg8_e
  logic taken;                      // goto condition holds
  logic other_ld;

  assign s  = step;
  assign sp = step_prime;

  always_comb begin
    casez (inst)
      8'b00??????: cls = relay_isa_pkg::IC_MOV8;
      8'b01??????: cls = relay_isa_pkg::IC_SETAB;
      8'b1000????: cls = relay_isa_pkg::IC_ALU;
      8'b100100??: cls = relay_isa_pkg::IC_LOAD;
      8'b100110??: cls = relay_isa_pkg::IC_STORE;
      8'b10110000: cls = relay_isa_pkg::IC_INC16;
      8'b10101110: cls = relay_isa_pkg::IC_HALT;
      8'b11??????: cls = relay_isa_pkg::IC_GOTO;
      default:     cls = relay_isa_pkg::IC_ILLEGAL;
    endcase
  end

  // no condition bits means unconditional
  assign taken = (inst[5:2] == 4'b0000) || (inst[5] && ccr.sign) || (inst[4] && ccr.carry)
               || (inst[3] && ccr.zero) || (inst[2] && !ccr.zero);

  always_comb begin
    ctrl      = '0;
    r8_ld     = '0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    ctrl.alu_fn   = relay_isa_pkg::alu_fn_e'(inst[2:0]);
    ctrl.alu_to_d = inst[3];
    // fetch, common to every instruction
    ctrl.sel_pc  = s[1];
    mem_read     = s[1];
    ctrl.ld_inst = s[1];
    ctrl.ld_inc  = s[1];           // INC <= PC + 1
    ctrl.sel_inc = s[3];
    ctrl.ld_pc   = s[3];
    case (cls)
      relay_isa_pkg::IC_MOV8: begin
        ctrl.sel_src    = relay_isa_pkg::reg8_e'(inst[2:0]);
        ctrl.sel_src_en = sp[6];
        r8_ld[inst[5:3]] = s[6];
      end
      relay_isa_pkg::IC_SETAB: begin
        ctrl.sel_imm = s[6];
        r8_ld[{2'b00, inst[5]}] = s[6];  // A or B
      end
      relay_isa_pkg::IC_ALU: begin
        ctrl.sel_alu = s[6];
        ctrl.ld_ccr  = s[6];
      end
      relay_isa_pkg::IC_LOAD: begin
        ctrl.sel_m = s[9];
        mem_read  |= s[9];
        r8_ld[{1'b0, inst[1:0]}] = s[9];
      end
      relay_isa_pkg::IC_STORE: begin
        ctrl.sel_src    = relay_isa_pkg::reg8_e'({1'b0, inst[1:0]});
        ctrl.sel_src_en = sp[9];
        ctrl.sel_m      = s[9];
        mem_write       = s[9];
      end
      relay_isa_pkg::IC_INC16: begin
        ctrl.sel_xy   = s[9];
        ctrl.ld_inc  |= s[9];
        ctrl.sel_inc |= s[11];
        ctrl.ld_xy    = s[11];
      end
      relay_isa_pkg::IC_GOTO: begin
        // high byte at 9, low byte at 17, PC bumped after each
        ctrl.sel_pc  |= s[9] | s[17] | (s[21] && inst[0]);
        mem_read     |= s[9] | s[17];
        ctrl.ld_j1    = s[9];
        ctrl.ld_j2    = s[17];
        ctrl.ld_inc  |= s[9] | s[17];
        ctrl.sel_inc |= s[11] | s[19];
        ctrl.ld_xy    = s[21] && inst[0];  // link
        ctrl.sel_j    = s[22] && taken;
        ctrl.ld_pc   |= s[11] | s[19] | (s[22] && taken);
      end
      default: ;                   // halt and illegal do nothing past fetch
    endcase
    ctrl.ld_a  = r8_ld[relay_isa_pkg::R_A];
    ctrl.ld_b  = r8_ld[relay_isa_pkg::R_B];
    ctrl.ld_c  = r8_ld[relay_isa_pkg::R_C];
    ctrl.ld_d  = r8_ld[relay_isa_pkg::R_D];
    ctrl.ld_m1 = r8_ld[relay_isa_pkg::R_M1];
    ctrl.ld_m2 = r8_ld[relay_isa_pkg::R_M2];
    ctrl.ld_x  = r8_ld[relay_isa_pkg::R_X];
    ctrl.ld_y  = r8_ld[relay_isa_pkg::R_Y];
  end

  always_comb begin
    case (cls)
      relay_isa_pkg::IC_LOAD, relay_isa_pkg::IC_STORE: inst_done = s[`RELAY_LEN_MEM];
      relay_isa_pkg::IC_INC16, relay_isa_pkg::IC_HALT: inst_done = s[`RELAY_LEN_INC];
      relay_isa_pkg::IC_GOTO:                          inst_done = s[`RELAY_LEN_GOTO];
      default:                                         inst_done = s[`RELAY_LEN_SHORT];
    endcase
  end

  assign halt_req = (cls == relay_isa_pkg::IC_HALT) && s[`RELAY_LEN_INC];

  assign other_ld = |r8_ld || ctrl.ld_j1 || ctrl.ld_j2 || ctrl.ld_xy || ctrl.ld_ccr;

  a_fetch_loads: assert property (@(posedge clk) disable iff (!rst_n)
    |s[`RELAY_FETCH_STEPS:1] |-> !other_ld);

  a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_read && mem_write));

endmodule

// ==== logic/register_file.sv ====
// register file: program registers, data bus source mux and address bus mux
`include "relay_defs.svh"

module register_file (
  input  logic                      clk,
  input  logic                      rst_n,
  input  relay_ctrl_pkg::ctrl_bus_t ctrl,
  input  logic [`RELAY_DATA_W-1:0]  mem_rdata,
  input  logic [`RELAY_DATA_W-1:0]  alu_result,
  input  logic [`RELAY_DATA_W-1:0]  imm,
  output logic [`RELAY_ADDR_W-1:0]  addr,
  output logic [`RELAY_DATA_W-1:0]  wdata,
  output logic [`RELAY_DATA_W-1:0]  inst,
  output logic [`RELAY_DATA_W-1:0]  b,
  output logic [`RELAY_DATA_W-1:0]  c
);

  logic [`RELAY_DATA_W-1:0] reg_a, reg_b, reg_c, reg_d;
  logic [`RELAY_DATA_W-1:0] reg_m1, reg_m2, reg_x, reg_y, reg_j1, reg_j2;
  logic [`RELAY_ADDR_W-1:0] pc, inc;
  logic [`RELAY_DATA_W-1:0] src;    // selected register
  logic [`RELAY_DATA_W-1:0] dbus;

  always_comb begin
    case (ctrl.sel_src)
      relay_isa_pkg::R_A:  src = reg_a;
      relay_isa_pkg::R_B:  src = reg_b;
      relay_isa_pkg::R_C:  src = reg_c;
      relay_isa_pkg::R_D:  src = reg_d;
      relay_isa_pkg::R_M1: src = reg_m1;
      relay_isa_pkg::R_M2: src = reg_m2;
      relay_isa_pkg::R_X:  src = reg_x;
      default:             src = reg_y;
    endcase
  end

  // memory drives the bus when nothing else does
  assign dbus = ctrl.sel_alu ? alu_result :
                ctrl.sel_imm ? imm :
                ctrl.sel_src_en ? src : mem_rdata;

  always_comb begin
    addr = '0;
    if (ctrl.sel_pc)       addr = pc;
    else if (ctrl.sel_m)   addr = {reg_m1, reg_m2};
    else if (ctrl.sel_xy)  addr = {reg_x, reg_y};
    else if (ctrl.sel_j)   addr = {reg_j1, reg_j2};
    else if (ctrl.sel_inc) addr = inc;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc   <= '0;
      inst <= '0;
    end else begin
      if (ctrl.ld_pc)   pc   <= addr;
      if (ctrl.ld_inst) inst <= dbus;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.ld_inc) inc <= addr + 1'b1;  // incrementer
    if (ctrl.ld_a || (ctrl.sel_alu && !ctrl.alu_to_d)) reg_a <= dbus;
    if (ctrl.ld_b) reg_b <= dbus;
    if (ctrl.ld_c) reg_c <= dbus;
    if (ctrl.ld_d || (ctrl.sel_alu && ctrl.alu_to_d)) reg_d <= dbus;
    if (ctrl.ld_m1) reg_m1 <= dbus;
    if (ctrl.ld_m2) reg_m2 <= dbus;
    if (ctrl.ld_j1) reg_j1 <= dbus;
    if (ctrl.ld_j2) reg_j2 <= dbus;
    if (ctrl.ld_xy) begin
      {reg_x, reg_y} <= addr;           // INC16 and goto link
    end else begin
      if (ctrl.ld_x) reg_x <= dbus;
      if (ctrl.ld_y) reg_y <= dbus;
    end
  end

  assign wdata = dbus;
  assign b     = reg_b;
  assign c     = reg_c;

  a_one_addr_src: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({ctrl.sel_pc, ctrl.sel_m, ctrl.sel_xy, ctrl.sel_j, ctrl.sel_inc}));

endmodule

// ==== logic/alu_unit.sv ====
// eight-bit alu on B and C with the condition-code register
`include "relay_defs.svh"

module alu_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`RELAY_DATA_W-1:0] b,
  input  logic [`RELAY_DATA_W-1:0] c,
  input  relay_isa_pkg::alu_fn_e   fn,
  input  logic                     ld_ccr,
  output logic [`RELAY_DATA_W-1:0] result,
  output relay_isa_pkg::ccr_t      ccr
);

  logic cy;  // carry out of the current function

  always_comb begin
    cy = 1'b0;
    case (fn)
      relay_isa_pkg::FN_ADD: {cy, result} = {1'b0, b} + {1'b0, c};
      relay_isa_pkg::FN_INC: {cy, result} = {1'b0, b} + 1'b1;
      relay_isa_pkg::FN_AND: result = b & c;
      relay_isa_pkg::FN_OR:  result = b | c;
      relay_isa_pkg::FN_XOR: result = b ^ c;
      relay_isa_pkg::FN_NOT: result = ~b;
      relay_isa_pkg::FN_SHL: {cy, result} = {b, 1'b0};  // msb into carry
      default:               result = '0;               // clr
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ccr <= '0;
    end else if (ld_ccr) begin
      ccr.sign  <= result[`RELAY_DATA_W-1];
      ccr.carry <= cy;
      ccr.zero  <= (result == '0);
    end
  end

endmodule

// ==== logic/relay_cpu.sv ====
// relay computer top: sequencer, decoder, register file and alu on the memory ports
`include "relay_defs.svh"

module relay_cpu (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     run,
  input  logic [`RELAY_DATA_W-1:0] mem_rdata,
  output logic                     mem_read,
  output logic                     mem_write,
  output logic [`RELAY_ADDR_W-1:0] mem_addr,
  output logic [`RELAY_DATA_W-1:0] mem_wdata,
  output logic                     halted
);

  logic [`RELAY_NUM_STEPS-1:0] step, step_prime;
  logic inst_done, halt_req;
  relay_ctrl_pkg::ctrl_bus_t ctrl;
  relay_ctrl_pkg::mem_bus_t  mem;
  relay_isa_pkg::ccr_t ccr;
  logic [`RELAY_DATA_W-1:0] inst, imm, b, c, alu_result;

  // SETAB immediate, sign-extended from 5 bits
  assign imm = {{(`RELAY_DATA_W-5){inst[4]}}, inst[4:0]};

  pulse_sequencer u_seq (.clk(clk), .rst_n(rst_n), .run(run), .inst_done(inst_done),
    .halt_req(halt_req), .step(step), .step_prime(step_prime), .halted(halted));

  instruction_decoder u_dec (.clk(clk), .rst_n(rst_n), .inst(inst), .step(step),
    .step_prime(step_prime), .ccr(ccr), .ctrl(ctrl), .mem_read(mem.mem_read),
    .mem_write(mem.mem_write), .inst_done(inst_done), .halt_req(halt_req));

  register_file u_regs (.clk(clk), .rst_n(rst_n), .ctrl(ctrl), .mem_rdata(mem_rdata),
    .alu_result(alu_result), .imm(imm), .addr(mem.addr), .wdata(mem.wdata),
    .inst(inst), .b(b), .c(c));

  alu_unit u_alu (.clk(clk), .rst_n(rst_n), .b(b), .c(c), .fn(ctrl.alu_fn),
    .ld_ccr(ctrl.ld_ccr), .result(alu_result), .ccr(ccr));

  assign mem_read  = mem.mem_read;
  assign mem_write = mem.mem_write;
  assign mem_addr  = mem.addr;
  assign mem_wdata = mem.wdata;

endmodule

// ==== dv/relay_cpu_tb.sv ====
// relay computer testbench with program image, memory model, bus checks, watchdog and summary
`include "relay_defs.svh"

module relay_cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    int                       cyc;
    logic [`RELAY_ADDR_W-1:0] addr;
    logic [`RELAY_DATA_W-1:0] data;
  } mem_ev_t;

  logic clk, rst_n, run, mem_read, mem_write, halted;
  logic [`RELAY_DATA_W-1:0] mem_rdata, mem_wdata;
  logic [`RELAY_ADDR_W-1:0] mem_addr;
  logic [7:0] mem [0:65535];
  logic [7:0] rv [0:7];                 // register model in A B C D M1 M2 X Y order
  logic sign, carry, zero;              // ccr model
  logic [15:0] p;                       // next program byte
  int t, cyc, rd_errs, wr_errs, other_errs;
  logic halt_seen;
  mem_ev_t rd_q[$], wr_q[$], ev;

  relay_cpu uut (.clk(clk), .rst_n(rst_n), .run(run), .mem_rdata(mem_rdata),
    .mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .halted(halted));

  assign mem_rdata = mem[mem_addr];     // combinational read answer

  always #20 clk = ~clk;

  function automatic mem_ev_t make_ev(int c, logic [15:0] a, logic [7:0] d);
    mem_ev_t e;
    e.cyc = c;
    e.addr = a;
    e.data = d;
    return e;
  endfunction

  task automatic fetch_op(input logic [7:0] opc, input int len);
    rd_q.push_back(make_ev(t, p, opc));
    mem[p] = opc;
    p = p + 1;
    t += len;
  endtask

  task automatic set_ab(input logic r, input logic [4:0] v);
    fetch_op({2'b01, r, v}, `RELAY_LEN_SHORT);
    rv[r] = {{3{v[4]}}, v};             // sign-extended
  endtask

  task automatic mov(input logic [2:0] d, input logic [2:0] s);
    fetch_op({2'b00, d, s}, `RELAY_LEN_SHORT);
    rv[d] = rv[s];
  endtask

  task automatic alu_op(input logic [2:0] fn, input logic to_d);
    logic [8:0] r;
    case (fn)
      3'd0: r = {1'b0, rv[1]} + {1'b0, rv[2]};
      3'd1: r = {1'b0, rv[1]} + 9'd1;
      3'd2: r = {1'b0, rv[1] & rv[2]};
      3'd3: r = {1'b0, rv[1] | rv[2]};
      3'd4: r = {1'b0, rv[1] ^ rv[2]};
      3'd5: r = {1'b0, ~rv[1]};
      3'd6: r = {rv[1], 1'b0};          // msb out into carry
      default: r = '0;
    endcase
    fetch_op({4'b1000, to_d, fn}, `RELAY_LEN_SHORT);
    rv[to_d ? 3 : 0] = r[7:0];
    {sign, carry, zero} = {r[7], r[8], r[7:0] == 8'h00};
  endtask

  task automatic store(input logic [1:0] rr);
    int t0;
    t0 = t;
    fetch_op({6'b100110, rr}, `RELAY_LEN_MEM);
    wr_q.push_back(make_ev(t0 + 8, {rv[4], rv[5]}, rv[rr]));
  endtask

  task automatic load(input logic [1:0] rr);
    int t0;
    t0 = t;
    fetch_op({6'b100100, rr}, `RELAY_LEN_MEM);
    rd_q.push_back(make_ev(t0 + 8, {rv[4], rv[5]}, mem[{rv[4], rv[5]}]));
    rv[rr] = mem[{rv[4], rv[5]}];
  endtask

  task automatic jump(input logic [3:0] cond, input logic link, input logic [15:0] target);
    int t0;
    logic tk;
    t0 = t;
    fetch_op({2'b11, cond, 1'b0, link}, `RELAY_LEN_GOTO);
    rd_q.push_back(make_ev(t0 + 8, p, target[15:8]));
    rd_q.push_back(make_ev(t0 + 16, p + 16'd1, target[7:0]));
    mem[p] = target[15:8];
    mem[p + 16'd1] = target[7:0];
    p = p + 16'd2;
    tk = (cond == 4'b0000) || (cond[3] && sign) || (cond[2] && carry)
         || (cond[1] && zero) || (cond[0] && !zero);
    if (link) {rv[6], rv[7]} = p;       // return address after the operands
    if (tk) p = target;
  endtask

  always @(posedge clk) begin
    if (!run) begin
      assert (!mem_read && !mem_write) else begin
        other_errs++;
        $display("memory strobe active while run is low at %0t", $time);
      end
    end else if (rst_n) begin
      if (mem_read) begin
        if (rd_q.size() == 0) begin
          other_errs++;
          $display("unexpected read at %0t, address %h", $time, mem_addr);
        end else begin
          ev = rd_q.pop_front();
          assert (cyc == ev.cyc) else begin
            rd_errs++;
            $display("read at %0t came in cycle %0d, expected %0d", $time, cyc, ev.cyc);
          end
          assert (mem_addr == ev.addr) else begin
            rd_errs++;
            $display("Error at %0t: mem_addr expected %h, got %h", $time, ev.addr, mem_addr);
          end
        end
      end
      if (mem_write) begin
        if (wr_q.size() == 0) begin
          other_errs++;
          $display("unexpected write at %0t, address %h", $time, mem_addr);
        end else begin
          ev = wr_q.pop_front();
          assert (cyc == ev.cyc) else begin
            wr_errs++;
            $display("write at %0t came in cycle %0d, expected %0d", $time, cyc, ev.cyc);
          end
          assert (mem_addr == ev.addr) else begin
            wr_errs++;
            $display("Error at %0t: mem_addr expected %h, got %h", $time, ev.addr, mem_addr);
          end
          assert (mem_wdata == ev.data) else begin
            wr_errs++;
            $display("Error at %0t: mem_wdata expected %h, got %h", $time, ev.data, mem_wdata);
          end
        end
        mem[mem_addr] = mem_wdata;
      end
      if (halted && !halt_seen) begin
        halt_seen = 1'b1;
        assert (cyc == t) else begin
          other_errs++;
          $display("halted rose in cycle %0d, expected %0d", cyc, t);
        end
      end
      cyc++;
    end
  end

  a_quiet_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
    halted |-> !mem_read && !mem_write)
    else begin
      other_errs++;
      $display("memory strobe after halt at %0t", $time);
    end

  a_halt_holds: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> halted)
    else begin
      other_errs++;
      $display("halted dropped at %0t", $time);
    end

  initial begin
    void'($urandom(32'hc3db_e1e8));
    clk = 1'b0;
    rst_n = 1'b0;
    run = 1'b0;
    {t, cyc, rd_errs, wr_errs, other_errs, halt_seen, p} = '0;
    {sign, carry, zero} = 3'b000;
    for (int i = 0; i < 65536; i++) mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
    set_ab(0, 5'h10);                   // M = f000 away from the program
    mov(4, 0);
    set_ab(1, 5'h00);
    mov(5, 1);
    set_ab(0, 5'($urandom));
    mov(2, 0);
    mov(3, 2);
    mov(6, 3);
    mov(7, 6);
    mov(0, 7);
    store(0);
    store(3);
    set_ab(1, 5'($urandom));
    store(1);
    for (int fn = 0; fn < 8; fn++) begin
      set_ab(0, 5'($urandom));
      mov(2, 0);
      set_ab(1, 5'($urandom));
      alu_op(3'(fn), fn[0]);
      store(fn[0] ? 2'd3 : 2'd0);
      for (int k = 0; k < 3; k++) jump(4'b1000 >> k, 1'b0, p + 16'd5);
    end
    set_ab(1, 5'h0f);                   // f00f still holds its fill byte
    mov(5, 1);
    load(2);
    set_ab(1, 5'h00);
    mov(5, 1);
    store(2);
    jump(4'b0000, 1'b1, p + 16'd9);
    fetch_op(8'hb0, `RELAY_LEN_INC);
    {rv[6], rv[7]} = {rv[6], rv[7]} + 16'd1;
    mov(0, 7);
    store(0);
    mov(1, 6);
    store(1);
    jump(4'b0001, 1'b0, 16'h0000);      // zero still set by clr so not taken
    fetch_op(8'hae, `RELAY_LEN_INC);
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    run <= 1'b1;
    wait (halted);
    repeat (8) @(posedge clk);
    if (rd_q.size() != 0 || wr_q.size() != 0) begin
      other_errs++;
      $display("%0d reads and %0d writes never happened", rd_q.size(), wr_q.size());
    end
    $display("summary: %0d read errors, %0d write errors, %0d other errors",
             rd_errs, wr_errs, other_errs);
    if (rd_errs + wr_errs + other_errs == 0) $display("=== PASS ===");
    else $display("=== FAIL ===");
    $finish;
  end

  initial begin
    #1;
    #((t + 60) * 40);
    $display("watchdog expired before the program halted");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/relay_isa_pkg.sv
logic/relay_ctrl_pkg.sv
logic/pulse_sequencer.sv
logic/instruction_decoder.sv
logic/register_file.sv
logic/alu_unit.sv
logic/relay_cpu.sv
dv/relay_cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the relay computer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module relay_cpu_tb -f vlog.f -o relay_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/relay_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "no result line in sim.log"
  exit 1
fi
exit 0
